//--- Bender.yml
package:
  name: axi_id_remap

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/axi_id_pkg.sv
      - logic/remap_pkg.sv
      - logic/id_remap_table.sv
      - logic/id_remap_ctrl.sv
      - logic/axi_id_remap.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_axi_id_remap.sv

//--- bench/tb_axi_id_remap.sv
// Directed testbench for the AXI ID remapper; acts as slave-side driver and master responder.
`timescale 1ns/1ps
`default_nettype none

module tb_axi_id_remap;

  // Upper bound for every wait on the DUT, in cycles.
  localparam int wait_limit = 100;
  // How long a stalled request is watched before capacity is freed.
  localparam int stall_cycles = 20;

  logic clk;
  logic rst_n;

  // Slave side of the DUT, driven by the testbench.
  logic               s_ar_valid;
  axi_id_pkg::in_id_t s_ar_id;
  axi_id_pkg::addr_t  s_ar_addr;
  axi_id_pkg::len_t   s_ar_len;
  logic               s_ar_ready;
  logic               s_aw_valid;
  axi_id_pkg::in_id_t s_aw_id;
  axi_id_pkg::addr_t  s_aw_addr;
  axi_id_pkg::len_t   s_aw_len;
  logic               s_aw_ready;
  logic               s_b_valid;
  axi_id_pkg::in_id_t s_b_id;
  axi_id_pkg::resp_t  s_b_resp;
  logic               s_b_ready;
  logic               s_r_valid;
  axi_id_pkg::in_id_t s_r_id;
  axi_id_pkg::data_t  s_r_data;
  axi_id_pkg::resp_t  s_r_resp;
  logic               s_r_last;
  logic               s_r_ready;

  // Master side of the DUT; the testbench plays the downstream slave.
  logic               m_ar_valid;
  remap_pkg::out_id_t m_ar_id;
  axi_id_pkg::addr_t  m_ar_addr;
  axi_id_pkg::len_t   m_ar_len;
  logic               m_ar_ready;
  logic               m_aw_valid;
  remap_pkg::out_id_t m_aw_id;
  axi_id_pkg::addr_t  m_aw_addr;
  axi_id_pkg::len_t   m_aw_len;
  logic               m_aw_ready;
  logic               m_b_valid;
  remap_pkg::out_id_t m_b_id;
  axi_id_pkg::resp_t  m_b_resp;
  logic               m_b_ready;
  logic               m_r_valid;
  remap_pkg::out_id_t m_r_id;
  axi_id_pkg::data_t  m_r_data;
  axi_id_pkg::resp_t  m_r_resp;
  logic               m_r_last;
  logic               m_r_ready;

  // Reference model of both tables: owning input ID and in-flight count per output ID.
  logic [7:0]  rd_model_id  [4];
  int          rd_model_cnt [4];
  logic [7:0]  wr_model_id  [4];
  int          wr_model_cnt [4];
  logic [31:0] lcg_state;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  axi_id_remap u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .s_ar_valid_i (s_ar_valid),
    .s_ar_id_i    (s_ar_id),
    .s_ar_addr_i  (s_ar_addr),
    .s_ar_len_i   (s_ar_len),
    .s_ar_ready_o (s_ar_ready),
    .s_aw_valid_i (s_aw_valid),
    .s_aw_id_i    (s_aw_id),
    .s_aw_addr_i  (s_aw_addr),
    .s_aw_len_i   (s_aw_len),
    .s_aw_ready_o (s_aw_ready),
    .s_b_valid_o  (s_b_valid),
    .s_b_id_o     (s_b_id),
    .s_b_resp_o   (s_b_resp),
    .s_b_ready_i  (s_b_ready),
    .s_r_valid_o  (s_r_valid),
    .s_r_id_o     (s_r_id),
    .s_r_data_o   (s_r_data),
    .s_r_resp_o   (s_r_resp),
    .s_r_last_o   (s_r_last),
    .s_r_ready_i  (s_r_ready),
    .m_ar_valid_o (m_ar_valid),
    .m_ar_id_o    (m_ar_id),
    .m_ar_addr_o  (m_ar_addr),
    .m_ar_len_o   (m_ar_len),
    .m_ar_ready_i (m_ar_ready),
    .m_aw_valid_o (m_aw_valid),
    .m_aw_id_o    (m_aw_id),
    .m_aw_addr_o  (m_aw_addr),
    .m_aw_len_o   (m_aw_len),
    .m_aw_ready_i (m_aw_ready),
    .m_b_valid_i  (m_b_valid),
    .m_b_id_i     (m_b_id),
    .m_b_resp_i   (m_b_resp),
    .m_b_ready_o  (m_b_ready),
    .m_r_valid_i  (m_r_valid),
    .m_r_id_i     (m_r_id),
    .m_r_data_i   (m_r_data),
    .m_r_resp_i   (m_r_resp),
    .m_r_last_i   (m_r_last),
    .m_r_ready_o  (m_r_ready)
  );

  // Linear congruential generator for addresses, data and response codes.
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // A live entry with the same input ID is reused, otherwise the lowest free entry is taken.
  function automatic logic [1:0] predict_out_id(input bit is_wr, input logic [7:0] in_id);
    for (int i = 0; i < 4; i++) begin
      if (is_wr ? (wr_model_cnt[i] > 0 && wr_model_id[i] == in_id)
                : (rd_model_cnt[i] > 0 && rd_model_id[i] == in_id)) begin
        return 2'(i);
      end
    end
    for (int i = 0; i < 4; i++) begin
      if ((is_wr ? wr_model_cnt[i] : rd_model_cnt[i]) == 0) begin
        return 2'(i);
      end
    end
    return 2'd0;
  endfunction

  task automatic model_push(input bit is_wr, input logic [1:0] out_id, input logic [7:0] in_id);
    if (is_wr) begin
      wr_model_id[out_id] = in_id;
      wr_model_cnt[out_id]++;
    end else begin
      rd_model_id[out_id] = in_id;
      rd_model_cnt[out_id]++;
    end
  endtask

  task automatic model_pop(input bit is_wr, input logic [1:0] out_id);
    if (is_wr) begin
      wr_model_cnt[out_id]--;
    end else begin
      rd_model_cnt[out_id]--;
    end
  endtask

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic compare(input string test, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string test, input string what);
    $display("Test %s gave up waiting: %s did not happen within %0d cycles.",
             test, what, wait_limit);
    abort_run();
  endtask

  // One R beat from the master side; the slave must see the restored input ID.
  task automatic send_r(input string test, input logic [1:0] out_id, input logic last);
    logic [31:0] data;
    data = lcg_next();
    @(negedge clk);
    m_r_valid = 1'b1;
    m_r_id    = out_id;
    m_r_data  = data;
    m_r_resp  = data[31:30];
    m_r_last  = last;
    #1;
    compare(test, "s_r_valid", 1, s_r_valid);
    compare(test, "s_r_id", rd_model_id[out_id], s_r_id);
    compare(test, "s_r_data", data, s_r_data);
    compare(test, "s_r_resp", data[31:30], s_r_resp);
    compare(test, "s_r_last", last, s_r_last);
    compare(test, "m_r_ready", 1, m_r_ready);
    if (last) begin
      model_pop(1'b0, out_id);
    end
    @(negedge clk);
    m_r_valid = 1'b0;
    m_r_last  = 1'b0;
  endtask

  task automatic send_b(input string test, input logic [1:0] out_id, input logic [1:0] resp);
    @(negedge clk);
    m_b_valid = 1'b1;
    m_b_id    = out_id;
    m_b_resp  = resp;
    #1;
    compare(test, "s_b_valid", 1, s_b_valid);
    compare(test, "s_b_id", wr_model_id[out_id], s_b_id);
    compare(test, "s_b_resp", resp, s_b_resp);
    compare(test, "m_b_ready", 1, m_b_ready);
    model_pop(1'b1, out_id);
    @(negedge clk);
    m_b_valid = 1'b0;
  endtask

  // Issues one AR.  With stall_len above zero the request must first be held back for that
  // many cycles, and is then released by the last R beat of release_id.
  task automatic send_ar(input string test, input logic [7:0] in_id, input logic [7:0] len,
                         input int stall_len, input logic [1:0] release_id,
                         output logic [1:0] out_id);
    logic [31:0] addr;
    logic [1:0]  exp_id;
    int          cycles;
    addr = lcg_next();
    @(negedge clk);
    s_ar_valid = 1'b1;
    s_ar_id    = in_id;
    s_ar_addr  = addr;
    s_ar_len   = len;
    #1;
    for (int i = 0; i < stall_len; i++) begin
      compare(test, "s_ar_ready during stall", 0, s_ar_ready);
      compare(test, "m_ar_valid during stall", 0, m_ar_valid);
      @(negedge clk);
      #1;
    end
    if (stall_len > 0) begin
      send_r(test, release_id, 1'b1);
      #1;
    end
    cycles = 0;
    while (!s_ar_ready) begin
      cycles++;
      if (cycles > wait_limit) begin
        report_timeout(test, "AR acceptance");
      end
      @(negedge clk);
      #1;
    end
    exp_id = predict_out_id(1'b0, in_id);
    compare(test, "m_ar_valid", 1, m_ar_valid);
    compare(test, "m_ar_id", exp_id, m_ar_id);
    compare(test, "m_ar_addr", addr, m_ar_addr);
    compare(test, "m_ar_len", len, m_ar_len);
    out_id = m_ar_id;
    model_push(1'b0, exp_id, in_id);
    @(negedge clk);
    s_ar_valid = 1'b0;
  endtask

  task automatic send_aw(input string test, input logic [7:0] in_id, input logic [7:0] len,
                         output logic [1:0] out_id);
    logic [31:0] addr;
    logic [1:0]  exp_id;
    int          cycles;
    addr = lcg_next();
    @(negedge clk);
    s_aw_valid = 1'b1;
    s_aw_id    = in_id;
    s_aw_addr  = addr;
    s_aw_len   = len;
    #1;
    cycles = 0;
    while (!s_aw_ready) begin
      cycles++;
      if (cycles > wait_limit) begin
        report_timeout(test, "AW acceptance");
      end
      @(negedge clk);
      #1;
    end
    exp_id = predict_out_id(1'b1, in_id);
    compare(test, "m_aw_valid", 1, m_aw_valid);
    compare(test, "m_aw_id", exp_id, m_aw_id);
    compare(test, "m_aw_addr", addr, m_aw_addr);
    compare(test, "m_aw_len", len, m_aw_len);
    out_id = m_aw_id;
    model_push(1'b1, exp_id, in_id);
    @(negedge clk);
    s_aw_valid = 1'b0;
  endtask

  // Completes everything still in flight so the next test starts from empty tables.
  task automatic drain_all(input string test);
    for (int i = 0; i < 4; i++) begin
      while (rd_model_cnt[i] > 0) begin
        send_r(test, 2'(i), 1'b1);
      end
      while (wr_model_cnt[i] > 0) begin
        send_b(test, 2'(i), 2'b00);
      end
    end
  endtask

  task automatic test_new_ids();
    logic [1:0] out_id;
    compare("new_ids", "m_ar_valid after reset", 0, m_ar_valid);
    compare("new_ids", "m_aw_valid after reset", 0, m_aw_valid);
    compare("new_ids", "s_ar_ready after reset", 0, s_ar_ready);
    compare("new_ids", "s_aw_ready after reset", 0, s_aw_ready);
    send_ar("new_ids", 8'h21, 8'd0, 0, 2'd0, out_id);
    compare("new_ids", "output ID of 0x21", 0, out_id);
    send_ar("new_ids", 8'h05, 8'd1, 0, 2'd0, out_id);
    compare("new_ids", "output ID of 0x05", 1, out_id);
    send_ar("new_ids", 8'h7F, 8'd7, 0, 2'd0, out_id);
    compare("new_ids", "output ID of 0x7F", 2, out_id);
  endtask

  task automatic test_reuse_restore();
    logic [1:0] out_id;
    send_ar("reuse_restore", 8'h05, 8'd1, 0, 2'd0, out_id);
    compare("reuse_restore", "reused output ID of 0x05", 1, out_id);
    send_r("reuse_restore", 2'd1, 1'b0);
    send_r("reuse_restore", 2'd1, 1'b1);
    // The second read still owns entry 1, so a new ID has to skip it.
    send_ar("reuse_restore", 8'h44, 8'd0, 0, 2'd0, out_id);
    compare("reuse_restore", "new ID while entry 1 is live", 3, out_id);
    send_r("reuse_restore", 2'd1, 1'b0);
    send_r("reuse_restore", 2'd1, 1'b1);
    send_ar("reuse_restore", 8'h66, 8'd0, 0, 2'd0, out_id);
    compare("reuse_restore", "new ID after entry 1 freed", 1, out_id);
    drain_all("reuse_restore");
  endtask

  task automatic test_id_limit();
    logic [1:0] out_id;
    for (int i = 0; i < 3; i++) begin
      send_ar("id_limit", 8'h33, 8'd0, 0, 2'd0, out_id);
      compare("id_limit", "output ID of 0x33", 0, out_id);
    end
    send_ar("id_limit", 8'h33, 8'd0, stall_cycles, 2'd0, out_id);
    compare("id_limit", "output ID after release", 0, out_id);
    drain_all("id_limit");
  endtask

  task automatic test_full_table();
    logic [1:0] out_id;
    for (int i = 0; i < 4; i++) begin
      send_ar("full_table", 8'h10 + 8'(i), 8'd0, 0, 2'd0, out_id);
      compare("full_table", "output ID of distinct read", i, out_id);
    end
    send_ar("full_table", 8'h14, 8'd2, stall_cycles, 2'd2, out_id);
    compare("full_table", "output ID after release", 2, out_id);
    drain_all("full_table");
  endtask

  task automatic test_directions();
    logic [1:0] out_id;
    send_aw("directions", 8'h5A, 8'd3, out_id);
    compare("directions", "write output ID", 0, out_id);
    send_ar("directions", 8'h5A, 8'd0, 0, 2'd0, out_id);
    compare("directions", "read output ID", 0, out_id);
    send_b("directions", 2'd0, 2'b10);
    send_r("directions", 2'd0, 1'b1);
    drain_all("directions");
  endtask

  // Master AR ready stays low for five cycles; the request must be offered unchanged.
  task automatic test_back_pressure();
    logic [31:0] addr;
    logic [1:0]  held_id;
    addr = lcg_next();
    @(negedge clk);
    m_ar_ready = 1'b0;
    s_ar_valid = 1'b1;
    s_ar_id    = 8'h77;
    s_ar_addr  = addr;
    s_ar_len   = 8'd4;
    #1;
    held_id = m_ar_id;
    compare("back_pressure", "m_ar_id", predict_out_id(1'b0, 8'h77), held_id);
    compare("back_pressure", "s_ar_ready in first cycle", 0, s_ar_ready);
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      #1;
      compare("back_pressure", "m_ar_valid while held", 1, m_ar_valid);
      compare("back_pressure", "m_ar_id while held", held_id, m_ar_id);
      compare("back_pressure", "s_ar_ready while held", 0, s_ar_ready);
    end
    @(negedge clk);
    m_ar_ready = 1'b1;
    #1;
    compare("back_pressure", "s_ar_ready when ready rises", 1, s_ar_ready);
    compare("back_pressure", "m_ar_valid when ready rises", 1, m_ar_valid);
    compare("back_pressure", "m_ar_id when ready rises", held_id, m_ar_id);
    compare("back_pressure", "m_ar_addr", addr, m_ar_addr);
    model_push(1'b0, held_id, 8'h77);
    @(negedge clk);
    s_ar_valid = 1'b0;
    drain_all("back_pressure");
  endtask

  initial begin
    int cycles;
    lcg_state  = 32'd77;
    s_ar_valid = 1'b0;
    s_ar_id    = '0;
    s_ar_addr  = '0;
    s_ar_len   = '0;
    s_aw_valid = 1'b0;
    s_aw_id    = '0;
    s_aw_addr  = '0;
    s_aw_len   = '0;
    s_b_ready  = 1'b1;
    s_r_ready  = 1'b1;
    m_ar_ready = 1'b1;
    m_aw_ready = 1'b1;
    m_b_valid  = 1'b0;
    m_b_id     = '0;
    m_b_resp   = '0;
    m_r_valid  = 1'b0;
    m_r_id     = '0;
    m_r_data   = '0;
    m_r_resp   = '0;
    m_r_last   = 1'b0;
    for (int i = 0; i < 4; i++) begin
      rd_model_id[i]  = '0;
      rd_model_cnt[i] = 0;
      wr_model_id[i]  = '0;
      wr_model_cnt[i] = 0;
    end

    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_limit) begin
        report_timeout("reset", "reset release");
      end
    end
    @(negedge clk);
    #1;

    test_new_ids();
    test_reuse_restore();
    test_id_limit();
    test_full_table();
    test_directions();
    test_back_pressure();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// Testbench clock and reset source for the ID remapper; 4 ns clock, reset held for 10 cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock with a 4 ns period.
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset is low for ten rising edges.
  // It is released on a falling edge, half a period away from any register update.
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/axi_id_pkg.sv
logic/remap_pkg.sv
logic/id_remap_table.sv
logic/id_remap_ctrl.sv
logic/axi_id_remap.sv
bench/tb_clock_gen.sv
bench/tb_axi_id_remap.sv

//--- include/remap_defs.svh
// Build-time sizes for the AXI ID remapper, included by its packages and the remap table.
`ifndef REMAP_DEFS_SVH
`define REMAP_DEFS_SVH

// Width of the sparse IDs that arrive on the slave side.
`define REMAP_IN_ID_W 8

// Width of the dense IDs sent to the master side.
// The same value indexes the remap tables.
`define REMAP_OUT_ID_W 2

// Number of table entries.
// This must equal 2 to the power of REMAP_OUT_ID_W so that every index is an entry.
`define REMAP_MAX_UNIQ_IDS 4

// Largest number of transactions one input ID may have in flight.
`define REMAP_MAX_TXNS 3

// Width of the per-entry counter.
// It has to hold the value REMAP_MAX_TXNS.
`define REMAP_CNT_W 2

// Address width of AR and AW.
`define REMAP_ADDR_W 32

// Data width of the R channel.
`define REMAP_DATA_W 32

`endif

//--- logic/axi_id_pkg.sv
// AXI field types for the remapper's slave and master ports; referenced by scoped name.
`default_nettype none

`include "remap_defs.svh"

package axi_id_pkg;

  // Slave-side transaction ID.
  // Only a few of these values are expected to be live at any time.
  typedef logic [`REMAP_IN_ID_W-1:0] in_id_t;

  // Byte address carried on AR and AW.
  typedef logic [`REMAP_ADDR_W-1:0] addr_t;

  // Burst length as AXI4 encodes it, beats minus one.
  typedef logic [7:0] len_t;

  // One beat of read data.
  typedef logic [`REMAP_DATA_W-1:0] data_t;

  // Response code on B and R (OKAY, EXOKAY, SLVERR, DECERR).
  typedef logic [1:0] resp_t;

endpackage

`default_nettype wire

//--- logic/axi_id_remap.sv
// AXI ID remapper top level: narrows sparse 8-bit IDs to dense 2-bit IDs and restores them.
`timescale 1ns/1ps
`default_nettype none

module axi_id_remap (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Slave port, AR channel.
  input  logic               s_ar_valid_i,
  input  axi_id_pkg::in_id_t s_ar_id_i,
  input  axi_id_pkg::addr_t  s_ar_addr_i,
  input  axi_id_pkg::len_t   s_ar_len_i,
  output logic               s_ar_ready_o,
  // Slave port, AW channel.
  input  logic               s_aw_valid_i,
  input  axi_id_pkg::in_id_t s_aw_id_i,
  input  axi_id_pkg::addr_t  s_aw_addr_i,
  input  axi_id_pkg::len_t   s_aw_len_i,
  output logic               s_aw_ready_o,
  // Slave port, B channel.
  output logic               s_b_valid_o,
  output axi_id_pkg::in_id_t s_b_id_o,
  output axi_id_pkg::resp_t  s_b_resp_o,
  input  logic               s_b_ready_i,
  // Slave port, R channel.
  output logic               s_r_valid_o,
  output axi_id_pkg::in_id_t s_r_id_o,
  output axi_id_pkg::data_t  s_r_data_o,
  output axi_id_pkg::resp_t  s_r_resp_o,
  output logic               s_r_last_o,
  input  logic               s_r_ready_i,
  // Master port, AR channel.
  output logic               m_ar_valid_o,
  output remap_pkg::out_id_t m_ar_id_o,
  output axi_id_pkg::addr_t  m_ar_addr_o,
  output axi_id_pkg::len_t   m_ar_len_o,
  input  logic               m_ar_ready_i,
  // Master port, AW channel.
  output logic               m_aw_valid_o,
  output remap_pkg::out_id_t m_aw_id_o,
  output axi_id_pkg::addr_t  m_aw_addr_o,
  output axi_id_pkg::len_t   m_aw_len_o,
  input  logic               m_aw_ready_i,
  // Master port, B channel.
  input  logic               m_b_valid_i,
  input  remap_pkg::out_id_t m_b_id_i,
  input  axi_id_pkg::resp_t  m_b_resp_i,
  output logic               m_b_ready_o,
  // Master port, R channel.
  input  logic               m_r_valid_i,
  input  remap_pkg::out_id_t m_r_id_i,
  input  axi_id_pkg::data_t  m_r_data_i,
  input  axi_id_pkg::resp_t  m_r_resp_i,
  input  logic               m_r_last_i,
  output logic               m_r_ready_o
);

  logic               wr_exists, wr_exists_full, wr_full, wr_push, wr_pop;
  logic               rd_exists, rd_exists_full, rd_full, rd_push, rd_pop;
  remap_pkg::out_id_t wr_exists_out_id, wr_free_out_id;
  remap_pkg::out_id_t rd_exists_out_id, rd_free_out_id;

  // Everything except IDs and request handshakes passes straight through.
  assign m_ar_addr_o = s_ar_addr_i;
  assign m_ar_len_o  = s_ar_len_i;
  assign m_aw_addr_o = s_aw_addr_i;
  assign m_aw_len_o  = s_aw_len_i;

  assign s_b_valid_o = m_b_valid_i;
  assign s_b_resp_o  = m_b_resp_i;
  assign m_b_ready_o = s_b_ready_i;

  assign s_r_valid_o = m_r_valid_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_last_o  = m_r_last_i;
  assign m_r_ready_o = s_r_ready_i;

  // Write table: looked up with the AW ID, retired by B, restores the B ID.
  id_remap_table u_wr_table (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .push_i          (wr_push),
    .push_in_id_i    (s_aw_id_i),
    .push_out_id_i   (m_aw_id_o),
    .lookup_id_i     (s_aw_id_i),
    .exists_o        (wr_exists),
    .exists_full_o   (wr_exists_full),
    .exists_out_id_o (wr_exists_out_id),
    .free_out_id_o   (wr_free_out_id),
    .full_o          (wr_full),
    .pop_i           (wr_pop),
    .pop_out_id_i    (m_b_id_i),
    .pop_in_id_o     (s_b_id_o)
  );

  // Read table: looked up with the AR ID, retired by the last R beat, restores the R ID.
  id_remap_table u_rd_table (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .push_i          (rd_push),
    .push_in_id_i    (s_ar_id_i),
    .push_out_id_i   (m_ar_id_o),
    .lookup_id_i     (s_ar_id_i),
    .exists_o        (rd_exists),
    .exists_full_o   (rd_exists_full),
    .exists_out_id_o (rd_exists_out_id),
    .free_out_id_o   (rd_free_out_id),
    .full_o          (rd_full),
    .pop_i           (rd_pop),
    .pop_out_id_i    (m_r_id_i),
    .pop_in_id_o     (s_r_id_o)
  );

  id_remap_ctrl u_ctrl (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .s_ar_valid_i       (s_ar_valid_i),
    .s_aw_valid_i       (s_aw_valid_i),
    .s_ar_ready_o       (s_ar_ready_o),
    .s_aw_ready_o       (s_aw_ready_o),
    .m_ar_valid_o       (m_ar_valid_o),
    .m_aw_valid_o       (m_aw_valid_o),
    .m_ar_ready_i       (m_ar_ready_i),
    .m_aw_ready_i       (m_aw_ready_i),
    .rd_exists_i        (rd_exists),
    .rd_exists_full_i   (rd_exists_full),
    .rd_full_i          (rd_full),
    .wr_exists_i        (wr_exists),
    .wr_exists_full_i   (wr_exists_full),
    .wr_full_i          (wr_full),
    .rd_exists_out_id_i (rd_exists_out_id),
    .rd_free_out_id_i   (rd_free_out_id),
    .wr_exists_out_id_i (wr_exists_out_id),
    .wr_free_out_id_i   (wr_free_out_id),
    .rd_push_o          (rd_push),
    .wr_push_o          (wr_push),
    .m_ar_id_o          (m_ar_id_o),
    .m_aw_id_o          (m_aw_id_o),
    .m_b_valid_i        (m_b_valid_i),
    .s_b_ready_i        (s_b_ready_i),
    .m_r_valid_i        (m_r_valid_i),
    .m_r_last_i         (m_r_last_i),
    .s_r_ready_i        (s_r_ready_i),
    .wr_pop_o           (wr_pop),
    .rd_pop_o           (rd_pop)
  );

endmodule

`default_nettype wire

//--- logic/id_remap_ctrl.sv
// Request controller of the ID remapper that forwards AR and AW, assigns output IDs and forms pops.
`timescale 1ns/1ps
`default_nettype none

module id_remap_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request handshakes on the slave side.
  input  logic               s_ar_valid_i,
  input  logic               s_aw_valid_i,
  output logic               s_ar_ready_o,
  output logic               s_aw_ready_o,
  // Request handshakes on the master side.
  output logic               m_ar_valid_o,
  output logic               m_aw_valid_o,
  input  logic               m_ar_ready_i,
  input  logic               m_aw_ready_i,
  // Lookup results from both tables.
  input  logic               rd_exists_i,
  input  logic               rd_exists_full_i,
  input  logic               rd_full_i,
  input  logic               wr_exists_i,
  input  logic               wr_exists_full_i,
  input  logic               wr_full_i,
  input  remap_pkg::out_id_t rd_exists_out_id_i,
  input  remap_pkg::out_id_t rd_free_out_id_i,
  input  remap_pkg::out_id_t wr_exists_out_id_i,
  input  remap_pkg::out_id_t wr_free_out_id_i,
  // Table pushes and the output IDs they use.
  output logic               rd_push_o,
  output logic               wr_push_o,
  output remap_pkg::out_id_t m_ar_id_o,
  output remap_pkg::out_id_t m_aw_id_o,
  // Response handshakes that retire transactions.
  input  logic               m_b_valid_i,
  input  logic               s_b_ready_i,
  input  logic               m_r_valid_i,
  input  logic               m_r_last_i,
  input  logic               s_r_ready_i,
  output logic               wr_pop_o,
  output logic               rd_pop_o
);

  // The hold states remember which master channel still waits for ready.
  typedef enum logic [1:0] {
    st_ready,
    st_hold_ar,
    st_hold_aw,
    st_hold_ax
  } state_t;

  state_t             state_q;
  state_t             state_d;
  remap_pkg::out_id_t ar_id_q;
  remap_pkg::out_id_t aw_id_q;
  logic               ar_load;
  logic               aw_load;
  logic               rd_ok;
  logic               wr_ok;

  // A request may go if its ID is live below the limit, or new with a free entry left.
  assign rd_ok = rd_exists_i ? !rd_exists_full_i : !rd_full_i;
  assign wr_ok = wr_exists_i ? !wr_exists_full_i : !wr_full_i;

  // A write retires on its B handshake, a read on the handshake of its last R beat.
  assign wr_pop_o = m_b_valid_i && s_b_ready_i;
  assign rd_pop_o = m_r_valid_i && s_r_ready_i && m_r_last_i;

  always_comb begin
    m_ar_valid_o = 1'b0;
    m_aw_valid_o = 1'b0;
    s_ar_ready_o = 1'b0;
    s_aw_ready_o = 1'b0;
    rd_push_o    = 1'b0;
    wr_push_o    = 1'b0;
    // Outside of Ready the held IDs are shown, which keeps them stable under back-pressure.
    m_ar_id_o    = ar_id_q;
    m_aw_id_o    = aw_id_q;
    ar_load      = 1'b0;
    aw_load      = 1'b0;
    state_d      = state_q;

    case (state_q)
      st_ready: begin
        // Reuse keeps per-ID ordering; a new ID takes the lowest free entry.
        m_ar_id_o = rd_exists_i ? rd_exists_out_id_i : rd_free_out_id_i;
        m_aw_id_o = wr_exists_i ? wr_exists_out_id_i : wr_free_out_id_i;

        // The push happens in the first cycle, even if the master is not ready yet.
        if (s_ar_valid_i && rd_ok) begin
          m_ar_valid_o = 1'b1;
          rd_push_o    = 1'b1;
          s_ar_ready_o = m_ar_ready_i;
          ar_load      = !m_ar_ready_i;
        end
        if (s_aw_valid_i && wr_ok) begin
          m_aw_valid_o = 1'b1;
          wr_push_o    = 1'b1;
          s_aw_ready_o = m_aw_ready_i;
          aw_load      = !m_aw_ready_i;
        end

        case ({ar_load, aw_load})
          2'b11:   state_d = st_hold_ax;
          2'b10:   state_d = st_hold_ar;
          2'b01:   state_d = st_hold_aw;
          default: state_d = st_ready;
        endcase
      end

      st_hold_ar: begin
        m_ar_valid_o = 1'b1;
        s_ar_ready_o = m_ar_ready_i;
        if (m_ar_ready_i) begin
          state_d = st_ready;
        end
      end

      st_hold_aw: begin
        m_aw_valid_o = 1'b1;
        s_aw_ready_o = m_aw_ready_i;
        if (m_aw_ready_i) begin
          state_d = st_ready;
        end
      end

      st_hold_ax: begin
        m_ar_valid_o = 1'b1;
        s_ar_ready_o = m_ar_ready_i;
        m_aw_valid_o = 1'b1;
        s_aw_ready_o = m_aw_ready_i;
        // Whichever channel finishes first leaves the other one holding.
        case ({m_ar_ready_i, m_aw_ready_i})
          2'b11:   state_d = st_ready;
          2'b10:   state_d = st_hold_aw;
          2'b01:   state_d = st_hold_ar;
          default: state_d = st_hold_ax;
        endcase
      end

      default: state_d = st_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= st_ready;
    end else begin
      state_q <= state_d;
    end
  end

  // The held IDs are captured only on the cycle a request meets back-pressure.
  always_ff @(posedge clk_i) begin
    if (ar_load) begin
      ar_id_q <= m_ar_id_o;
    end
    if (aw_load) begin
      aw_id_q <= m_aw_id_o;
    end
  end

  // A request the master has not taken is still offered, unchanged, one cycle later.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_id_o))
    else $error("AR valid dropped or ID changed under back-pressure");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o && $stable(m_aw_id_o))
    else $error("AW valid dropped or ID changed under back-pressure");

  // The slave only sees acceptance when the master takes the request too.
  // A held request must also still be offered by the slave when the master takes it.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_ar_valid_i && s_ar_ready_o) == (m_ar_valid_o && m_ar_ready_i))
    else $error("AR transfer on one side without a transfer on the other");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_aw_valid_i && s_aw_ready_o) == (m_aw_valid_o && m_aw_ready_i))
    else $error("AW transfer on one side without a transfer on the other");

endmodule

`default_nettype wire

//--- logic/id_remap_table.sv
// Remap table for one direction: maps input IDs to output IDs and counts what is in flight.
`timescale 1ns/1ps
`default_nettype none

`include "remap_defs.svh"

module id_remap_table (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Push side, used when a request is forwarded.
  input  logic                 push_i,
  input  axi_id_pkg::in_id_t   push_in_id_i,
  input  remap_pkg::out_id_t   push_out_id_i,
  // Lookup of the ID of the request that is waiting on the slave side.
  input  axi_id_pkg::in_id_t   lookup_id_i,
  output logic                 exists_o,
  output logic                 exists_full_o,
  output remap_pkg::out_id_t   exists_out_id_o,
  // Lowest free entry, only meaningful while full_o is low.
  output remap_pkg::out_id_t   free_out_id_o,
  output logic                 full_o,
  // Pop side, driven by the last response of a transaction.
  input  logic                 pop_i,
  input  remap_pkg::out_id_t   pop_out_id_i,
  output axi_id_pkg::in_id_t   pop_in_id_o
);

  // Counter value at which an entry accepts no further push.
  localparam remap_pkg::cnt_t cnt_max = remap_pkg::cnt_t'(`REMAP_MAX_TXNS);

  // One table entry is the input ID that owns it plus its in-flight count.
  typedef struct packed {
    axi_id_pkg::in_id_t in_id;
    remap_pkg::cnt_t    cnt;
  } entry_t;

  entry_t entry_q [`REMAP_MAX_UNIQ_IDS];
  entry_t entry_d [`REMAP_MAX_UNIQ_IDS];

  // One bit per entry: the entry is idle, or it is live and owned by the lookup ID.
  logic [`REMAP_MAX_UNIQ_IDS-1:0] free_vec;
  logic [`REMAP_MAX_UNIQ_IDS-1:0] match;

  // Each entry gets its own comparator against the lookup ID.
  // An entry with a zero count never matches, whatever ID it still holds.
  always_comb begin
    for (int i = 0; i < `REMAP_MAX_UNIQ_IDS; i++) begin
      free_vec[i] = (entry_q[i].cnt == '0);
      match[i]    = (entry_q[i].cnt != '0) && (entry_q[i].in_id == lookup_id_i);
    end
  end

  // Lowest-index search over the free entries.
  // Walking downwards lets the lowest free index win the last assignment.
  always_comb begin
    free_out_id_o = '0;
    for (int i = `REMAP_MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_out_id_o = remap_pkg::out_id_t'(i);
      end
    end
  end

  assign full_o = ~|free_vec;

  // At most one bit of match is set, so encoding it is a plain OR of indices.
  always_comb begin
    exists_out_id_o = '0;
    for (int i = 0; i < `REMAP_MAX_UNIQ_IDS; i++) begin
      if (match[i]) begin
        exists_out_id_o = remap_pkg::out_id_t'(i);
      end
    end
  end

  assign exists_o      = |match;
  assign exists_full_o = (entry_q[exists_out_id_o].cnt == cnt_max);

  // The response path reads back the original ID straight from the registered table.
  assign pop_in_id_o = entry_q[pop_out_id_i].in_id;

  // Next table state.
  // Push and pop are applied one after the other, so both on one entry cancel out.
  always_comb begin
    entry_d = entry_q;
    if (push_i) begin
      entry_d[push_out_id_i].in_id = push_in_id_i;
      entry_d[push_out_id_i].cnt   = entry_d[push_out_id_i].cnt + remap_pkg::cnt_t'(1);
    end
    if (pop_i) begin
      entry_d[pop_out_id_i].cnt = entry_d[pop_out_id_i].cnt - remap_pkg::cnt_t'(1);
    end
  end

  // Only the counters are cleared on reset.
  // The stored IDs are ignored until their counter becomes nonzero.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `REMAP_MAX_UNIQ_IDS; i++) begin
        entry_q[i].cnt <= '0;
      end
    end else begin
      entry_q <= entry_d;
    end
  end

  // The controller must hold back a request whose ID is already at its limit.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> entry_q[push_out_id_i].cnt != cnt_max)
    else $error("push into an entry that is already at the per-ID limit");

  // A response may only retire an output ID that has something in flight.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> entry_q[pop_out_id_i].cnt != '0)
    else $error("pop of an output ID with nothing in flight");

  // Reuse on push keeps every live input ID in a single entry.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(match))
    else $error("input ID found in more than one live entry");

endmodule

`default_nettype wire

//--- logic/remap_pkg.sv
// Remap table types shared by the ID tables, the request controller and the top level.
`default_nettype none

`include "remap_defs.svh"

package remap_pkg;

  // Dense master-side ID.
  // It doubles as the index of the table entry that holds the mapping.
  typedef logic [`REMAP_OUT_ID_W-1:0] out_id_t;

  // Count of transactions in flight for one table entry.
  // A value of zero marks the entry as free.
  typedef logic [`REMAP_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire
